// ==== project.f ====
verilog/rv_decode_pkg.sv
verilog/pipe_reg.sv
verilog/main_decoder.sv
verilog/alu_decoder.sv
verilog/imm_extender.sv
verilog/decode_stage.sv
test/decode_stage_chk.sv
test/decode_stage_tb.sv

// ==== test/decode_stage_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_chk import rv_decode_pkg::*; (
    input logic   clk_i,
    input logic   reset_i,
    input logic   stall_i,
    input logic   flush_i,
    input id_ex_t ex_i
);

    int fail_count = 0; // Read by the testbench summary

    reset_clears: assert property (@(posedge clk_i) reset_i |=> !ex_i.valid)
        else begin
            $error("ex_o still valid one cycle after reset");
            fail_count++;
        end

    flush_bubbles: assert property (@(posedge clk_i) flush_i |=> !ex_i.valid)
        else begin
            $error("ex_o still valid one cycle after flush");
            fail_count++;
        end

    // Stall freezes the ID/EX register
    stall_holds: assert property (@(posedge clk_i)
        (stall_i && !flush_i && !reset_i) |=> $stable(ex_i))
        else begin
            $error("ex_o changed during a stall");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== test/decode_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb import rv_decode_pkg::*; ();

    typedef struct packed {
        logic [31:0] instr;
        logic [6:0]  ctl;   // reg_wr, mem_wr, branch, result_src, alu_src, a_sel, signed
        byte_en_t    be;
        alu_ctrl_e   alu;
        logic [31:0] imm;
    } vec_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        stall;
    logic        flush;
    id_ex_t      ex;

    vec_t        vec_q[$];
    id_ex_t      exp_q[$]; // Entry 0 mirrors ID/EX, entry 1 mirrors IF/ID
    int          idx_q[$]; // Table index per stage, -1 for a bubble
    bit          seen[64];
    int          next_idx;
    int          drv_idx;
    int          errors;
    int          checks;
    logic [31:0] lfsr;

    decode_stage UUT (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .stall_i       (stall),
        .flush_i       (flush),
        .ex_o          (ex)
    );

    bind decode_stage decode_stage_chk u_chk (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .ex_i    (ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003; // Galois taps 32, 22, 2, 1
        end
        return b;
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic add_vec(input logic [31:0] word, input logic [6:0] ctl, input byte_en_t be,
                           input alu_ctrl_e alu, input logic [31:0] imm);
        vec_q.push_back(vec_t'{word, ctl, be, alu, imm});
    endtask

    task automatic load_table();
        add_vec({12'hffc, 5'd1, 3'h0, 5'd2, OP_LOAD}, 7'b1001101, 4'b0001, ADD, 32'hffff_fffc);
        add_vec({12'h010, 5'd4, 3'h1, 5'd3, OP_LOAD}, 7'b1001101, 4'b0011, ADD, 32'h0000_0010);
        add_vec({12'h7ff, 5'd6, 3'h2, 5'd5, OP_LOAD}, 7'b1001101, 4'b1111, ADD, 32'h0000_07ff);
        add_vec({12'h001, 5'd8, 3'h4, 5'd7, OP_LOAD}, 7'b1001100, 4'b0001, ADD, 32'h0000_0001);
        add_vec({12'h800, 5'd10, 3'h5, 5'd9, OP_LOAD}, 7'b1001100, 4'b0011, ADD, 32'hffff_f800);
        add_vec(enc_s(12'hfff, 5'd11, 5'd12, 3'h0), 7'b0101100, 4'b0001, ADD, 32'hffff_ffff);
        add_vec(enc_s(12'h024, 5'd13, 5'd14, 3'h1), 7'b0101100, 4'b0011, ADD, 32'h0000_0024);
        add_vec(enc_s(12'h7fc, 5'd15, 5'd16, 3'h2), 7'b0101100, 4'b1111, ADD, 32'h0000_07fc);
        add_vec({12'hffb, 5'd2, 3'h0, 5'd1, OP_IMM}, 7'b1000101, 4'b0000, ADD, 32'hffff_fffb);
        add_vec({12'h400, 5'd3, 3'h0, 5'd4, OP_IMM}, 7'b1000101, 4'b0000, ADD, 32'h0000_0400);
        add_vec({12'hfff, 5'd5, 3'h3, 5'd6, OP_IMM}, 7'b1000100, 4'b0000, SLTU, 32'hffff_ffff);
        add_vec({12'h007, 5'd6, 3'h1, 5'd5, OP_IMM}, 7'b1000100, 4'b0000, SLL, 32'h0000_0007);
        add_vec({12'h01f, 5'd7, 3'h5, 5'd8, OP_IMM}, 7'b1000100, 4'b0000, SRL, 32'h0000_001f);
        add_vec({12'h403, 5'd9, 3'h5, 5'd9, OP_IMM}, 7'b1000101, 4'b0000, SRA, 32'h0000_0003);
        add_vec({12'h800, 5'd1, 3'h6, 5'd2, OP_IMM}, 7'b1000101, 4'b0000, OR, 32'hffff_f800);
        add_vec({7'h00, 5'd3, 5'd2, 3'h0, 5'd1, OP_REG}, 7'b1000001, 4'b0000, ADD, 32'h0);
        add_vec({7'h20, 5'd3, 5'd2, 3'h0, 5'd1, OP_REG}, 7'b1000001, 4'b0000, SUB, 32'h0);
        add_vec({7'h20, 5'd5, 5'd4, 3'h5, 5'd6, OP_REG}, 7'b1000001, 4'b0000, SRA, 32'h0);
        add_vec({7'h00, 5'd8, 5'd7, 3'h3, 5'd9, OP_REG}, 7'b1000000, 4'b0000, SLTU, 32'h0);
        add_vec(enc_b(13'h1ff8, 5'd2, 5'd1, 3'h0), 7'b0010001, 4'b0000, SUB, 32'hffff_fff8);
        add_vec(enc_b(13'h0ffe, 5'd4, 5'd3, 3'h6), 7'b0010000, 4'b0000, SUB, 32'h0000_0ffe);
        add_vec(enc_j(21'h1f0ff0, 5'd1), 7'b1011100, 4'b0000, ADD, 32'hffff_0ff0);
        add_vec({12'h010, 5'd5, 3'h0, 5'd1, OP_JALR}, 7'b1011101, 4'b0000, ADD, 32'h0000_0010);
        add_vec({20'habcde, 5'd7, OP_LUI}, 7'b1000110, 4'b0000, ADD, 32'habcd_e000);
        add_vec({20'h00001, 5'd8, OP_AUIPC}, 7'b1000110, 4'b0000, ADD, 32'h0000_1000);
        add_vec(32'h0000_41ff, 7'b0000000, 4'b0000, XOR, 32'h0); // Illegal opcode, funct3 4
    endtask

    function automatic id_ex_t expected_for(int k, logic [31:0] at_pc);
        id_ex_t e;
        vec_t   v;
        v = vec_q[k];
        e.valid = 1'b1;
        e.pc = at_pc;
        e.rs1 = v.instr[19:15];
        e.rs2 = v.instr[24:20];
        e.rd = v.instr[11:7];
        {e.reg_wr_en, e.mem_wr_en, e.branch, e.result_src, e.alu_src, e.alu_src_a_sel,
         e.signed_ext} = v.ctl;
        e.byte_en = v.be;
        e.alu_ctrl = v.alu;
        e.imm = v.imm;
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic compare_bundle(input id_ex_t e);
        check("valid", ex.valid, e.valid);
        check("pc", ex.pc, e.pc);
        check("rs1", ex.rs1, e.rs1);
        check("rs2", ex.rs2, e.rs2);
        check("rd", ex.rd, e.rd);
        check("reg_wr_en", ex.reg_wr_en, e.reg_wr_en);
        check("mem_wr_en", ex.mem_wr_en, e.mem_wr_en);
        check("branch", ex.branch, e.branch);
        check("result_src", ex.result_src, e.result_src);
        check("alu_src", ex.alu_src, e.alu_src);
        check("alu_src_a_sel", ex.alu_src_a_sel, e.alu_src_a_sel);
        check("signed_ext", ex.signed_ext, e.signed_ext);
        check("byte_en", ex.byte_en, e.byte_en);
        check("alu_ctrl", ex.alu_ctrl, e.alu_ctrl);
        check("imm", ex.imm, e.imm);
    endtask

    task automatic clear_model();
        exp_q = {};
        idx_q = {};
        repeat (2) begin
            exp_q.push_back(id_ex_t'(0));
            idx_q.push_back(-1);
        end
    endtask

    // Reference pipeline, advanced on the same edge as the DUT
    always @(posedge clk) begin
        if (reset || flush) begin
            clear_model();
        end else if (!stall) begin
            void'(exp_q.pop_front());
            void'(idx_q.pop_front());
            if (instr_valid) begin
                exp_q.push_back(expected_for(drv_idx, pc));
                idx_q.push_back(drv_idx);
            end else begin
                exp_q.push_back(id_ex_t'(0));
                idx_q.push_back(-1);
            end
        end
    end

    task automatic step(input bit use_table);
        logic s;
        logic f;
        @(negedge clk);
        compare_bundle(exp_q[0]);
        if (ex.valid && idx_q[0] >= 0) begin
            seen[idx_q[0]] = 1'b1;
        end
        if (use_table) begin
            s = rand_bit();
            s = s & rand_bit();
            f = rand_bit();
            f = f & rand_bit();
            f = f & rand_bit();
            stall = s;
            flush = f;
            instr_valid = 1'b1;
            instr = vec_q[next_idx].instr;
            pc = 32'h0000_1000 + 32'(next_idx * 4);
            drv_idx = next_idx;
            if (f) begin
                if (idx_q[1] >= 0) begin
                    next_idx = idx_q[1]; // Refetch from the squashed instruction
                end
            end else if (!s) begin
                next_idx++;
            end
        end else begin
            stall = 1'b0;
            flush = 1'b0;
            instr_valid = 1'b0;
            instr = 32'h0;
            pc = 32'h0;
            drv_idx = -1;
        end
    endtask

    initial begin
        lfsr = 32'hd7e3;
        errors = 0;
        checks = 0;
        next_idx = 0;
        drv_idx = -1;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        instr_valid = 1'b1; // Live instruction held through reset
        instr = {20'hfffff, 5'd31, OP_LUI};
        pc = 32'hffff_fffc;
        load_table();
        clear_model();
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_bundle(exp_q[0]); // ID/EX straight out of reset
        reset = 1'b0;
        instr_valid = 1'b0;
        instr = 32'h0;
        pc = 32'h0;
        repeat (2) step(1'b0); // Idle after reset
        while (next_idx < vec_q.size()) begin
            step(1'b1);
        end
        repeat (3) step(1'b0); // Drain both stages
        for (int k = 0; k < vec_q.size(); k++) begin
            if (!seen[k]) begin
                errors++;
                $display("table entry %0d never reached ex_o", k);
            end
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_chk.fail_count);
        if (errors == 0 && UUT.u_chk.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #1;
        repeat (vec_q.size() * 8 + 50) @(posedge clk);
        $display("timeout: the table did not complete in the allowed cycles");
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_chk.fail_count);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/alu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import rv_decode_pkg::*; (
    input  alu_op_e    alu_op_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7_b5_i, // Instruction bit 30
    output alu_ctrl_e  alu_ctrl_o
);

    logic is_reg; // Register form may select SUB

    assign is_reg = (alu_op_i == ALUOP_REG);

    always_comb begin
        alu_ctrl_o = ADD;
        case (alu_op_i)
            ALUOP_IMM, ALUOP_REG: begin
                case (funct3_i)
                    3'h0: begin
                        // ADDI never subtracts, even with bit 30 set
                        if (is_reg && funct7_b5_i) begin
                            alu_ctrl_o = SUB;
                        end else begin
                            alu_ctrl_o = ADD;
                        end
                    end
                    3'h1: alu_ctrl_o = SLL;
                    3'h2: alu_ctrl_o = SLT;
                    3'h3: alu_ctrl_o = SLTU;
                    3'h4: alu_ctrl_o = XOR;
                    3'h5: begin
                        if (funct7_b5_i) begin
                            alu_ctrl_o = SRA; // SRA and SRAI
                        end else begin
                            alu_ctrl_o = SRL;
                        end
                    end
                    3'h6: alu_ctrl_o = OR;
                    3'h7: alu_ctrl_o = AND;
                    default: alu_ctrl_o = ADD;
                endcase
            end

            ALUOP_BRANCH: begin
                alu_ctrl_o = SUB; // Compare by subtraction
            end

            default: begin
                alu_ctrl_o = ADD; // ALUOP_ADD
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_decode_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic        stall_i,
    input  logic        flush_i,
    output id_ex_t      ex_o
);

    if_id_t    if_id_d;
    if_id_t    if_id_q;
    id_ex_t    id_ex_d;

    logic      reg_wr_en;
    logic      mem_wr_en;
    imm_src_e  imm_src;
    logic      alu_src;
    logic      branch;
    logic      result_src;
    alu_op_e   alu_op;
    byte_en_t  byte_en;
    logic      alu_src_a_sel;
    logic      signed_ext;
    alu_ctrl_e alu_ctrl;
    logic [31:0] imm;

    assign if_id_d = '{valid: instr_valid_i, pc: pc_i, instr: instr_i};

    pipe_reg #(.T(if_id_t)) u_if_id (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    main_decoder u_main_decoder (
        .opcode_i        (if_id_q.instr[6:0]),
        .funct3_i        (if_id_q.instr[14:12]),
        .funct7_i        (if_id_q.instr[31:25]),
        .reg_wr_en_o     (reg_wr_en),
        .mem_wr_en_o     (mem_wr_en),
        .imm_src_o       (imm_src),
        .alu_src_o       (alu_src),
        .branch_o        (branch),
        .result_src_o    (result_src),
        .alu_op_o        (alu_op),
        .byte_en_o       (byte_en),
        .alu_src_a_sel_o (alu_src_a_sel),
        .signed_o        (signed_ext)
    );

    alu_decoder u_alu_decoder (
        .alu_op_i    (alu_op),
        .funct3_i    (if_id_q.instr[14:12]),
        .funct7_b5_i (if_id_q.instr[30]),
        .alu_ctrl_o  (alu_ctrl)
    );

    imm_extender u_imm_extender (
        .instr_i   (if_id_q.instr),
        .imm_src_i (imm_src),
        .imm_o     (imm)
    );

    always_comb begin
        id_ex_d.valid         = if_id_q.valid;
        id_ex_d.pc            = if_id_q.pc;
        id_ex_d.rs1           = if_id_q.instr[19:15];
        id_ex_d.rs2           = if_id_q.instr[24:20];
        id_ex_d.rd            = if_id_q.instr[11:7];
        id_ex_d.reg_wr_en     = reg_wr_en;
        id_ex_d.mem_wr_en     = mem_wr_en;
        id_ex_d.branch        = branch;
        id_ex_d.result_src    = result_src;
        id_ex_d.alu_src       = alu_src;
        id_ex_d.alu_src_a_sel = alu_src_a_sel;
        id_ex_d.signed_ext    = signed_ext;
        id_ex_d.byte_en       = byte_en;
        id_ex_d.alu_ctrl      = alu_ctrl;
        id_ex_d.imm           = imm;
    end

    pipe_reg #(.T(id_ex_t)) u_id_ex (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .d_i     (id_ex_d),
        .q_o     (ex_o)
    );

endmodule

`default_nettype wire

// ==== verilog/imm_extender.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_extender import rv_decode_pkg::*; (
    input  logic [31:0] instr_i,
    input  imm_src_e    imm_src_i,
    output logic [31:0] imm_o
);

    logic sign; // Instruction bit 31 is the sign for all formats

    assign sign = instr_i[31];

    always_comb begin
        case (imm_src_i)
            IMM_I: imm_o = {{21{sign}}, instr_i[30:20]};
            IMM_S: imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            IMM_B: begin
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {instr_i[31:12], 12'b0}; // Upper 20 bits
            IMM_J: begin
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            IMM_SHAMT: imm_o = {27'b0, instr_i[24:20]}; // Shift amount
            default:   imm_o = 32'b0; // IMM_NONE
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/main_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_decoder import rv_decode_pkg::*; (
    input  logic [6:0] opcode_i,
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,

    output logic       reg_wr_en_o,
    output logic       mem_wr_en_o,
    output imm_src_e   imm_src_o,
    output logic       alu_src_o,       // Operand B is the immediate
    output logic       branch_o,        // Branches and jumps
    output logic       result_src_o,    // Memory data or link address
    output alu_op_e    alu_op_o,
    output byte_en_t   byte_en_o,
    output logic       alu_src_a_sel_o, // Operand A is PC or zero
    output logic       signed_o
);

    always_comb begin
        // Idle controls, also the illegal-opcode result
        reg_wr_en_o     = 1'b0;
        mem_wr_en_o     = 1'b0;
        imm_src_o       = IMM_I;
        alu_src_o       = 1'b0;
        branch_o        = 1'b0;
        result_src_o    = 1'b0;
        alu_op_o        = ALUOP_IMM;
        byte_en_o       = BE_NONE;
        alu_src_a_sel_o = 1'b0;
        signed_o        = 1'b0;

        case (opcode_i)
            OP_LOAD: begin
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = 1'b1; // Write back load data
                alu_op_o     = ALUOP_ADD;
                imm_src_o    = IMM_I;
                case (funct3_i)
                    3'h0: begin
                        byte_en_o = BE_BYTE; // LB
                        signed_o  = 1'b1;
                    end
                    3'h1: begin
                        byte_en_o = BE_HALF; // LH
                        signed_o  = 1'b1;
                    end
                    3'h2: begin
                        byte_en_o = BE_WORD; // LW
                        signed_o  = 1'b1;
                    end
                    3'h4: byte_en_o = BE_BYTE; // LBU
                    3'h5: byte_en_o = BE_HALF; // LHU
                    default: byte_en_o = BE_NONE;
                endcase
            end

            OP_IMM: begin
                reg_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = ALUOP_IMM;
                case (funct3_i)
                    3'h1: begin
                        imm_src_o = IMM_SHAMT; // SLLI
                    end
                    3'h5: begin
                        imm_src_o = IMM_SHAMT;   // SRLI / SRAI
                        signed_o  = funct7_i[5]; // Arithmetic shift
                    end
                    3'h3: begin
                        imm_src_o = IMM_I; // SLTIU compares unsigned
                    end
                    default: begin
                        imm_src_o = IMM_I;
                        signed_o  = 1'b1;
                    end
                endcase
            end

            OP_STORE: begin
                mem_wr_en_o  = 1'b1;
                imm_src_o    = IMM_S;
                alu_src_o    = 1'b1;
                result_src_o = 1'b1;
                alu_op_o     = ALUOP_ADD; // Effective address
                case (funct3_i)
                    3'h0:    byte_en_o = BE_BYTE; // SB
                    3'h1:    byte_en_o = BE_HALF; // SH
                    3'h2:    byte_en_o = BE_WORD; // SW
                    default: byte_en_o = BE_NONE;
                endcase
            end

            OP_REG: begin
                reg_wr_en_o = 1'b1;
                alu_op_o    = ALUOP_REG;
                imm_src_o   = IMM_NONE; // No immediate
                case (funct3_i)
                    3'h1:    signed_o = 1'b0;
                    3'h3:    signed_o = 1'b0;        // SLTU
                    3'h5:    signed_o = funct7_i[5]; // SRA
                    default: signed_o = 1'b1;
                endcase
            end

            OP_BRANCH: begin
                imm_src_o = IMM_B;
                branch_o  = 1'b1;
                alu_op_o  = ALUOP_BRANCH;
                // BLTU and BGEU compare unsigned
                signed_o  = (funct3_i != 3'h6) && (funct3_i != 3'h7);
            end

            OP_JAL: begin
                branch_o     = 1'b1;
                imm_src_o    = IMM_J;
                alu_src_o    = 1'b1;
                reg_wr_en_o  = 1'b1;
                result_src_o = 1'b1; // Link address
                alu_op_o     = ALUOP_ADD;
            end

            OP_JALR: begin
                branch_o     = 1'b1;
                imm_src_o    = IMM_I;
                alu_src_o    = 1'b1;
                reg_wr_en_o  = 1'b1;
                result_src_o = 1'b1;
                alu_op_o     = ALUOP_IMM; // funct3 0 resolves to ADD
                signed_o     = 1'b1;
            end

            OP_LUI, OP_AUIPC: begin
                reg_wr_en_o     = 1'b1;
                alu_src_o       = 1'b1;
                imm_src_o       = IMM_U;
                alu_op_o        = ALUOP_ADD;
                alu_src_a_sel_o = 1'b1; // Zero for LUI, PC for AUIPC
            end

            default: begin
                reg_wr_en_o = 1'b0; // Unknown opcode stays idle
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic stall_i, // Hold current contents
    input  logic flush_i, // Insert a bubble
    input  T     d_i,
    output T     q_o
);

    T q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            q <= T'('0);
        end else if (flush_i) begin
            q <= T'('0); // Bubble, valid low
        end else if (!stall_i) begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

`default_nettype wire

// ==== verilog/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    // RV32I base opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef logic [3:0] byte_en_t;

    // Byte-lane masks for memory access widths
    localparam byte_en_t BE_NONE = 4'b0000;
    localparam byte_en_t BE_BYTE = 4'b0001;
    localparam byte_en_t BE_HALF = 4'b0011;
    localparam byte_en_t BE_WORD = 4'b1111;

    typedef enum logic [2:0] {
        IMM_I     = 3'b000,
        IMM_S     = 3'b001,
        IMM_B     = 3'b010,
        IMM_U     = 3'b011,
        IMM_J     = 3'b100,
        IMM_SHAMT = 3'b101,
        IMM_NONE  = 3'b111
    } imm_src_e;

    typedef enum logic [1:0] {
        ALUOP_IMM    = 2'b00, // OP-IMM and JALR
        ALUOP_BRANCH = 2'b01,
        ALUOP_REG    = 2'b10,
        ALUOP_ADD    = 2'b11  // Address and upper-immediate math
    } alu_op_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_ctrl_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        reg_wr_en;
        logic        mem_wr_en;
        logic        branch;
        logic        result_src;    // 1 selects memory or PC+4
        logic        alu_src;       // 1 selects immediate as operand B
        logic        alu_src_a_sel; // Operand A from PC or zero
        logic        signed_ext;
        byte_en_t    byte_en;
        alu_ctrl_e   alu_ctrl;
        logic [31:0] imm;
    } id_ex_t;

endpackage

`default_nettype wire
